// File: Bender.yml
package:
  name: cpuTop

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/isaPkg.sv
      - design/ctrlPkg.sv
      - design/claAdder.sv
      - design/alu.sv
      - design/regFile.sv
      - design/controlUnit.sv
      - design/datapath.sv
      - design/cpuTop.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - bench/clockGen.sv
      - bench/cpuTop_asserts.sv
      - bench/cpuTopTb.sv

// File: bench/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // four reset edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: bench/cpuTopTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpuTopTb;

    localparam int MemWords = 256;
    localparam int RandomCount = 48;
    localparam int ResetTimeout = 20;
    localparam int EndTimeout = 20000;
    localparam int ModelStepLimit = 4000;

    logic                       clk;
    logic                       reset;
    logic [`CPU_DATA_WIDTH-1:0] wbAdr;
    logic [`CPU_DATA_WIDTH-1:0] wbDatW;
    logic                       wbWe;
    logic                       wbCyc;
    logic                       wbStb;
    logic [`CPU_DATA_WIDTH-1:0] wbDatR;
    logic                       wbAck;
    logic                       outValid;
    logic [`CPU_DATA_WIDTH-1:0] outData;

    logic [31:0] mem [MemWords];
    logic [31:0] modelMem [MemWords];
    logic [31:0] expOut [$];
    logic [31:0] expWrIdx [$];
    logic [31:0] expWrData [$];
    logic [31:0] rngState;
    logic [7:0]  haltIdx;
    int          progLen;
    int          haltFetches;
    int          errorCount;
    logic        busy;
    int unsigned waitLeft;

    clockGen clockGen_i (
        .clk  (clk),
        .reset(reset)
    );

    cpuTop dut_i (
        .clk     (clk),
        .reset   (reset),
        .wbAdr   (wbAdr),
        .wbDatW  (wbDatW),
        .wbWe    (wbWe),
        .wbCyc   (wbCyc),
        .wbStb   (wbStb),
        .wbDatR  (wbDatR),
        .wbAck   (wbAck),
        .outValid(outValid),
        .outData (outData)
    );

    bind cpuTop cpuTopAsserts asserts_i (
        .clk     (clk),
        .reset   (reset),
        .wbAdr   (wbAdr),
        .wbDatW  (wbDatW),
        .wbWe    (wbWe),
        .wbCyc   (wbCyc),
        .wbStb   (wbStb),
        .wbAck   (wbAck),
        .outValid(outValid)
    );

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    task automatic stopOnError(input string msg);
        errorCount++;
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            stopOnError($sformatf("MISMATCH at %0t ns: %s got %h, expected %h",
                                  $time, what, actual, expected));
        end
    endtask

    // field order: class, op or kind/variant, rs, rt, rd, imm
    function automatic logic [31:0] aluRegWord(logic [3:0] op, logic [3:0] rd,
                                               logic [3:0] rs, logic [3:0] rt);
        return {isaPkg::aluReg, op, rs, rt, rd, 14'd0};
    endfunction

    function automatic logic [31:0] aluImmWord(logic [3:0] op, logic [3:0] rd,
                                               logic [3:0] rs, logic [13:0] imm);
        return {isaPkg::aluImm, op, rs, 4'd0, rd, imm};
    endfunction

    function automatic logic [31:0] branchWord(logic [1:0] cond, logic [3:0] rs,
                                               logic [13:0] imm);
        return {isaPkg::branch, 2'b00, cond, rs, 4'd0, 4'd0, imm};
    endfunction

    function automatic logic [31:0] specialWord(logic [3:0] kind, logic [3:0] rd,
                                                logic [3:0] rs, logic [3:0] rt,
                                                logic [13:0] imm);
        return {isaPkg::special, kind, rs, rt, rd, imm};
    endfunction

    function automatic logic [31:0] outWord(logic [3:0] rs, logic [3:0] rt);
        return specialWord(isaPkg::kindOut, 4'd0, rs, rt, 14'd0);
    endfunction

    // reference ALU, written from the operation list
    function automatic logic [31:0] aluModel(logic [3:0] op, logic [31:0] a, logic [31:0] b);
        logic [31:0] res;
        case (op)
            4'd0: res = a + b;
            4'd1: res = a - b;
            4'd2: res = a & b;
            4'd3: res = a | b;
            4'd4: res = a ^ b;
            4'd5: res = ~a;
            4'd6: res = b[0] ? a << 1 : a;
            4'd7: begin
                if (b[0]) begin
                    res = $signed(a) >>> 1;
                end else begin
                    res = a;
                end
            end
            4'd8: res = b[0] ? a >> 1 : a;
            4'd9: res = b;
            default: res = '0;
        endcase
        return res;
    endfunction

    function automatic logic branchTaken(logic [1:0] cond, logic [31:0] a);
        case (cond)
            2'b00: return 1'b1;
            2'b01: return a[31];
            2'b10: return !a[31];
            default: return a == 32'd0;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[progLen] = word;
        progLen++;
    endtask

    // taken skips the first out
    task automatic branchCase(input logic [1:0] cond, input logic [3:0] rs);
        emit(branchWord(cond, rs, 14'd4));
        emit(outWord(4'd8, 4'd8));
        emit(outWord(4'd7, 4'd6));
    endtask

    task automatic buildProgram();
        logic [31:0] r;
        logic [31:0] s;
        logic [3:0]  rd;
        logic [13:0] dataOff;
        for (int i = 0; i < MemWords; i++) begin
            mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'h3c};
        end
        progLen = 0;
        // r2 is odd so the shifts move
        r = nextRandom();
        emit(aluImmWord(isaPkg::opPass, 4'd1, 4'd0, r[13:0]));
        emit(aluImmWord(isaPkg::opPass, 4'd2, 4'd0, {r[26:14], 1'b1}));
        emit(aluImmWord(isaPkg::opPass, 4'd15, 4'd0, 14'h0300));
        for (int op = 0; op < 10; op++) begin
            r = nextRandom();
            emit(aluRegWord(op[3:0], 4'd3, 4'd1, 4'd2));
            emit(outWord(4'd3, 4'd0));
            emit(aluImmWord(op[3:0], 4'd4, 4'd1, r[13:0]));
            emit(outWord(4'd4, 4'd0));
        end
        // store then load back through r15
        emit(specialWord(isaPkg::kindStore, 4'd0, 4'd15, 4'd1, 14'd8));
        emit(specialWord(isaPkg::kindLoad, 4'd5, 4'd15, 4'd0, 14'd8));
        emit(outWord(4'd5, 4'd0));
        emit(specialWord(isaPkg::kindStore, 4'd0, 4'd15, 4'd2, 14'd12));
        emit(specialWord(isaPkg::kindLoad, 4'd9, 4'd15, 4'd0, 14'd12));
        emit(outWord(4'd9, 4'd0));
        // negative, zero and positive operands for the branches
        emit(aluImmWord(isaPkg::opPass, 4'd6, 4'd0, 14'h3ffb));
        emit(aluImmWord(isaPkg::opPass, 4'd7, 4'd0, 14'd0));
        emit(aluImmWord(isaPkg::opPass, 4'd8, 4'd0, 14'd7));
        branchCase(isaPkg::condAlways, 4'd7);
        branchCase(isaPkg::condNegative, 4'd6);
        branchCase(isaPkg::condNegative, 4'd8);
        branchCase(isaPkg::condNonNegative, 4'd8);
        branchCase(isaPkg::condNonNegative, 4'd6);
        branchCase(isaPkg::condZero, 4'd7);
        branchCase(isaPkg::condZero, 4'd8);
        // random part keeps r15 as data base, rd in 1..13
        for (int i = 0; i < RandomCount; i++) begin
            r = nextRandom();
            s = nextRandom();
            rd = 4'(1 + r[7:4] % 13);
            dataOff = {6'd0, r[29:24], 2'b00};
            case (r[2:0])
                3'd0, 3'd1: emit(aluRegWord(r[19:16], rd, r[11:8], r[15:12]));
                3'd2, 3'd3: emit(aluImmWord(r[19:16], rd, r[11:8], s[13:0]));
                3'd4: emit(branchWord(r[21:20], r[11:8], {10'd0, r[23:22], 2'b00}));
                3'd5: emit(specialWord(isaPkg::kindLoad, rd, 4'd15, 4'd0, dataOff));
                3'd6: emit(specialWord(isaPkg::kindStore, 4'd0, 4'd15, r[15:12], dataOff));
                default: emit(outWord(r[11:8], r[15:12]));
            endcase
        end
        for (int i = 0; i < 4; i++) begin
            r = nextRandom();
            emit(outWord(r[3:0], r[7:4]));
        end
        // halt as a branch to itself
        emit(branchWord(isaPkg::condAlways, 4'd0, 14'h3ffc));
    endtask

    task automatic runModel();
        logic [31:0] regs [`CPU_REG_COUNT];
        logic [31:0] pc;
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] target;
        int          steps;
        logic        done;
        for (int i = 0; i < `CPU_REG_COUNT; i++) begin
            regs[i] = '0;
        end
        pc = `CPU_RESET_PC;
        done = 1'b0;
        steps = 0;
        while (!done && steps < ModelStepLimit) begin
            word = modelMem[pc[9:2]];
            a = regs[word[25:22]];
            b = regs[word[21:18]];
            imm = {{18{word[13]}}, word[13:0]};
            addr = a + imm;
            target = pc + `CPU_PC_STEP + imm;
            case (word[31:30])
                2'b00: regs[word[17:14]] = aluModel(word[29:26], a, b);
                2'b01: regs[word[17:14]] = aluModel(word[29:26], a, imm);
                2'b10: begin
                    if (branchTaken(word[27:26], a) && target == pc) begin
                        done = 1'b1;
                        haltIdx = pc[9:2];
                    end
                end
                default: begin
                    case (word[29:26])
                        isaPkg::kindLoad: regs[word[17:14]] = modelMem[addr[9:2]];
                        isaPkg::kindStore: begin
                            modelMem[addr[9:2]] = b;
                            expWrIdx.push_back({24'd0, addr[9:2]});
                            expWrData.push_back(b);
                        end
                        isaPkg::kindOut: expOut.push_back(a + b);
                        default: ;
                    endcase
                end
            endcase
            if (word[31:30] == 2'b10 && branchTaken(word[27:26], a)) begin
                pc = target;
            end else begin
                pc = pc + `CPU_PC_STEP;
            end
            steps++;
        end
        if (!done) begin
            stopOnError("reference model never reached the halt loop");
        end
    endtask

    task automatic serveAccess();
        logic [7:0] idx;
        idx = wbAdr[9:2];
        if (wbWe) begin
            if (expWrIdx.size() == 0) begin
                stopOnError("write on the bus that the model does not expect");
            end else begin
                checkEqual({24'd0, idx}, expWrIdx.pop_front(), "store word index");
                checkEqual(wbDatW, expWrData.pop_front(), "store data");
                mem[idx] = wbDatW;
            end
        end else begin
            wbDatR = mem[idx];
            if (idx == haltIdx) begin
                haltFetches++;
            end
        end
    endtask

    // memory slave, 0 to 3 wait cycles per access
    always @(negedge clk) begin
        if (reset) begin
            wbAck = 1'b0;
            busy = 1'b0;
        end else if (wbAck) begin
            wbAck = 1'b0;
            busy = 1'b0;
        end else if (wbCyc && wbStb) begin
            if (!busy) begin
                busy = 1'b1;
                waitLeft = nextRandom() % 4;
            end
            if (waitLeft == 0) begin
                serveAccess();
                wbAck = 1'b1;
            end else begin
                waitLeft--;
            end
        end
    end

    // out port monitor
    always @(negedge clk) begin
        if (outValid === 1'b1) begin
            if (expOut.size() == 0) begin
                stopOnError("out pulse after the last expected value");
            end else begin
                checkEqual(outData, expOut.pop_front(), "outData");
            end
        end
    end

    initial begin
        int cycles;
        wbAck = 1'b0;
        wbDatR = '0;
        busy = 1'b0;
        waitLeft = 0;
        haltFetches = 0;
        errorCount = 0;
        haltIdx = '0;
        rngState = 32'h4d2c;
        buildProgram();
        for (int i = 0; i < MemWords; i++) begin
            modelMem[i] = mem[i];
        end
        runModel();

        // outputs stay quiet while reset is held
        cycles = 0;
        @(posedge clk);
        while (reset && cycles < ResetTimeout) begin
            @(negedge clk);
            checkEqual(wbCyc, 1'b0, "wbCyc in reset");
            checkEqual(wbStb, 1'b0, "wbStb in reset");
            checkEqual(outValid, 1'b0, "outValid in reset");
            @(posedge clk);
            cycles++;
        end
        if (reset) begin
            stopOnError("reset was never released");
        end

        // first fetch one cycle after reset falls
        @(negedge clk);
        checkEqual(wbCyc, 1'b1, "wbCyc on first fetch");
        checkEqual(wbWe, 1'b0, "wbWe on first fetch");
        checkEqual(wbAdr, `CPU_RESET_PC, "first fetch address");

        cycles = 0;
        while (!(expOut.size() == 0 && haltFetches >= 2) && cycles < EndTimeout) begin
            @(posedge clk);
            cycles++;
        end
        if (expOut.size() != 0 || haltFetches < 2) begin
            stopOnError("timeout before the program reached the halt loop");
        end

        checkEqual(expWrIdx.size(), 0, "stores still pending");
        for (int i = 0; i < MemWords; i++) begin
            checkEqual(mem[i], modelMem[i], $sformatf("memory word %0d", i));
        end

        if (errorCount == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "errors were found");
        end
    end

endmodule

`default_nettype wire

// File: bench/cpuTop_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpuTopAsserts (
    input logic                       clk,
    input logic                       reset,
    input logic [`CPU_DATA_WIDTH-1:0] wbAdr,
    input logic [`CPU_DATA_WIDTH-1:0] wbDatW,
    input logic                       wbWe,
    input logic                       wbCyc,
    input logic                       wbStb,
    input logic                       wbAck,
    input logic                       outValid
);

    stbWithCyc: assert property (@(posedge clk) disable iff (reset)
        wbStb == wbCyc)
        else $error("wbStb and wbCyc differ");

    // request held until the slave acks
    holdRequest: assert property (@(posedge clk) disable iff (reset)
        wbStb && !wbAck |=> $stable(wbAdr) && $stable(wbWe) && $stable(wbDatW))
        else $error("bus request changed before wbAck");

    dropAfterAck: assert property (@(posedge clk) disable iff (reset)
        wbStb && wbAck |=> !wbStb)
        else $error("wbStb still high in the cycle after wbAck");

    // out pulses only come in writeback, never during a bus cycle
    outWhileIdle: assert property (@(posedge clk) disable iff (reset)
        outValid |-> !wbCyc)
        else $error("outValid high during a bus cycle");

endmodule

`default_nettype wire

// File: cpuTop.f
+incdir+design
design/isaPkg.sv
design/ctrlPkg.sv
design/claAdder.sv
design/alu.sv
design/regFile.sv
design/controlUnit.sv
design/datapath.sv
design/cpuTop.sv
bench/clockGen.sv
bench/cpuTop_asserts.sv
bench/cpuTopTb.sv

// File: design/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module alu (
    input  isaPkg::aluOp               func,
    input  logic [`CPU_DATA_WIDTH-1:0] opA,
    input  logic [`CPU_DATA_WIDTH-1:0] opB,
    output logic [`CPU_DATA_WIDTH-1:0] result
);

    logic                       isSub;
    logic [`CPU_DATA_WIDTH-1:0] adderB;
    logic [`CPU_DATA_WIDTH-1:0] adderSum;
    logic                       shiftOne;

    // subtract as a plus not b plus one
    assign isSub = (func == isaPkg::opSub);
    assign adderB = isSub ? ~opB : opB;

    claAdder adder_i (
        .a      (opA),
        .b      (adderB),
        .carryIn(isSub),
        .sum    (adderSum)
    );

    // shift amount is only bit 0
    assign shiftOne = opB[0];

    always_comb begin
        result = '0;
        case (func)
            isaPkg::opAdd,
            isaPkg::opSub:  result = adderSum;
            isaPkg::opAnd:  result = opA & opB;
            isaPkg::opOr:   result = opA | opB;
            isaPkg::opXor:  result = opA ^ opB;
            isaPkg::opNot:  result = ~opA;
            isaPkg::opShl:  result = shiftOne ? {opA[`CPU_DATA_WIDTH-2:0], 1'b0} : opA;
            isaPkg::opSra: begin
                // sign bit stays
                result = shiftOne ? {opA[`CPU_DATA_WIDTH-1], opA[`CPU_DATA_WIDTH-1:1]} : opA;
            end
            isaPkg::opSrl:  result = shiftOne ? {1'b0, opA[`CPU_DATA_WIDTH-1:1]} : opA;
            isaPkg::opPass: result = opB;
            default:        result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/claAdder.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module claAdder (
    input  logic [`CPU_DATA_WIDTH-1:0] a,
    input  logic [`CPU_DATA_WIDTH-1:0] b,
    input  logic                       carryIn,
    output logic [`CPU_DATA_WIDTH-1:0] sum
);

    localparam int Groups = `CPU_DATA_WIDTH / 4;

    // carry into each 4-bit group
    logic [Groups-1:0] groupCarry;

    assign groupCarry[0] = carryIn;

    for (genvar g = 0; g < Groups; g++) begin : genGroup
        logic [3:0] p;
        logic [3:0] gen;
        logic [3:0] c;

        assign p = a[4*g +: 4] ^ b[4*g +: 4];
        assign gen = a[4*g +: 4] & b[4*g +: 4];

        assign c[0] = groupCarry[g];
        assign c[1] = gen[0] | (p[0] & c[0]);
        assign c[2] = gen[1] | (p[1] & gen[0]) | (p[1] & p[0] & c[0]);
        assign c[3] = gen[2] | (p[2] & gen[1]) | (p[2] & p[1] & gen[0])
                    | (p[2] & p[1] & p[0] & c[0]);

        assign sum[4*g +: 4] = p ^ c;

        // group generate/propagate feed the next group
        if (g < Groups - 1) begin : genChain
            logic groupGen;
            logic groupProp;

            assign groupGen = gen[3] | (p[3] & gen[2]) | (p[3] & p[2] & gen[1])
                            | (p[3] & p[2] & p[1] & gen[0]);
            assign groupProp = &p;
            assign groupCarry[g+1] = groupGen | (groupProp & c[0]);
        end
    end

endmodule

`default_nettype wire

// File: design/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic             clk,
    input  logic             reset,
    input  isaPkg::instrWord instr,
    input  logic             condMet,
    input  logic             wbAck,
    output logic             wbCyc,
    output logic             wbStb,
    output logic             wbWe,
    output logic             irLoad,
    output logic             abLoad,
    output logic             aluOutLoad,
    output logic             lmdLoad,
    output logic             regWrite,
    output logic             pcLoad,
    output logic             busUseAlu,
    output logic             outValid,
    output ctrlPkg::operandA selA,
    output ctrlPkg::operandB selB,
    output isaPkg::aluOp     aluFunc
);

    ctrlPkg::cpuState   state;
    isaPkg::specialKind kind;
    logic               isAluClass;
    logic               isBranch;
    logic               isSpecial;
    logic               isLoad;
    logic               isStore;
    logic               isOut;
    logic               busDone;

    assign kind = isaPkg::specialKind'({instr.ctlForm.kind, instr.ctlForm.variant});

    assign isAluClass = (instr.aluForm.cls == isaPkg::aluReg)
                     || (instr.aluForm.cls == isaPkg::aluImm);
    assign isBranch = (instr.aluForm.cls == isaPkg::branch);
    assign isSpecial = (instr.aluForm.cls == isaPkg::special);
    assign isLoad = isSpecial && (kind == isaPkg::kindLoad);
    assign isStore = isSpecial && (kind == isaPkg::kindStore);
    assign isOut = isSpecial && (kind == isaPkg::kindOut);

    assign busDone = wbCyc && wbAck;
    assign wbStb = wbCyc;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ctrlPkg::fetch;
            wbCyc <= 1'b0;
            wbWe <= 1'b0;
        end else begin
            case (state)
                ctrlPkg::fetch: begin
                    if (busDone) begin
                        wbCyc <= 1'b0;
                        state <= ctrlPkg::decode;
                    end else if (!wbCyc) begin
                        // only the first fetch after reset gets here
                        wbCyc <= 1'b1;
                    end
                end
                ctrlPkg::decode: begin
                    state <= ctrlPkg::execute;
                end
                ctrlPkg::execute: begin
                    if (isLoad || isStore) begin
                        wbCyc <= 1'b1;
                        wbWe <= isStore;
                        state <= ctrlPkg::memory;
                    end else begin
                        state <= ctrlPkg::writeback;
                    end
                end
                ctrlPkg::memory: begin
                    if (busDone) begin
                        wbCyc <= 1'b0;
                        wbWe <= 1'b0;
                        state <= ctrlPkg::writeback;
                    end
                end
                ctrlPkg::writeback: begin
                    // next fetch goes out straight away
                    wbCyc <= 1'b1;
                    state <= ctrlPkg::fetch;
                end
                default: begin
                    state <= ctrlPkg::fetch;
                end
            endcase
        end
    end

    assign irLoad = (state == ctrlPkg::fetch) && busDone;
    assign abLoad = (state == ctrlPkg::decode);
    assign aluOutLoad = (state == ctrlPkg::execute);
    assign lmdLoad = (state == ctrlPkg::memory) && busDone && isLoad;
    assign regWrite = (state == ctrlPkg::writeback) && (isAluClass || isLoad);
    assign pcLoad = (state == ctrlPkg::writeback);
    assign outValid = (state == ctrlPkg::writeback) && isOut;

    // data address in memory, branch target on a taken branch
    assign busUseAlu = (state == ctrlPkg::memory)
                    || ((state == ctrlPkg::writeback) && isBranch && condMet);

    always_comb begin
        selA = ctrlPkg::regA;
        selB = ctrlPkg::regB;
        aluFunc = isaPkg::opAdd;
        case (instr.aluForm.cls)
            isaPkg::aluReg: begin
                aluFunc = instr.aluForm.op;
            end
            isaPkg::aluImm: begin
                selB = ctrlPkg::immediate;
                aluFunc = instr.aluForm.op;
            end
            isaPkg::branch: begin
                selA = ctrlPkg::nextPc;
                selB = ctrlPkg::immediate;
            end
            default: begin
                // load and store form an address, out adds A and B
                if (isLoad || isStore) begin
                    selB = ctrlPkg::immediate;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpuTop (
    input  logic                       clk,
    input  logic                       reset,
    output logic [`CPU_DATA_WIDTH-1:0] wbAdr,
    output logic [`CPU_DATA_WIDTH-1:0] wbDatW,
    output logic                       wbWe,
    output logic                       wbCyc,
    output logic                       wbStb,
    input  logic [`CPU_DATA_WIDTH-1:0] wbDatR,
    input  logic                       wbAck,
    output logic                       outValid,
    output logic [`CPU_DATA_WIDTH-1:0] outData
);

    isaPkg::instrWord instr;
    logic             condMet;
    logic             irLoad;
    logic             abLoad;
    logic             aluOutLoad;
    logic             lmdLoad;
    logic             regWrite;
    logic             pcLoad;
    logic             busUseAlu;
    ctrlPkg::operandA selA;
    ctrlPkg::operandB selB;
    isaPkg::aluOp     aluFunc;

    controlUnit controlUnit_i (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .condMet   (condMet),
        .wbAck     (wbAck),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .irLoad    (irLoad),
        .abLoad    (abLoad),
        .aluOutLoad(aluOutLoad),
        .lmdLoad   (lmdLoad),
        .regWrite  (regWrite),
        .pcLoad    (pcLoad),
        .busUseAlu (busUseAlu),
        .outValid  (outValid),
        .selA      (selA),
        .selB      (selB),
        .aluFunc   (aluFunc)
    );

    datapath datapath_i (
        .clk       (clk),
        .reset     (reset),
        .irLoad    (irLoad),
        .abLoad    (abLoad),
        .aluOutLoad(aluOutLoad),
        .lmdLoad   (lmdLoad),
        .regWrite  (regWrite),
        .pcLoad    (pcLoad),
        .busUseAlu (busUseAlu),
        .selA      (selA),
        .selB      (selB),
        .aluFunc   (aluFunc),
        .wbDatR    (wbDatR),
        .instr     (instr),
        .condMet   (condMet),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .outData   (outData)
    );

endmodule

`default_nettype wire

// File: design/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// word size of registers, bus data and byte addresses
`define CPU_DATA_WIDTH 32

// register file geometry
`define CPU_REG_COUNT 16
`define CPU_REG_ADDR_WIDTH 4

// immediate field, sign-extended to a full word
`define CPU_IMM_WIDTH 14

// fetch starts here after reset
`define CPU_RESET_PC 32'h0000_0000

// byte addresses of whole words
`define CPU_PC_STEP 32'd4

`endif

// File: design/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    // one pass per instruction, memory only for load and store
    typedef enum logic [2:0] {
        fetch     = 3'd0,
        decode    = 3'd1,
        execute   = 3'd2,
        memory    = 3'd3,
        writeback = 3'd4
    } cpuState;

    // first ALU operand
    typedef enum logic {
        regA   = 1'b0,
        nextPc = 1'b1
    } operandA;

    // second ALU operand
    typedef enum logic {
        regB      = 1'b0,
        immediate = 1'b1
    } operandB;

endpackage

`default_nettype wire

// File: design/datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module datapath (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       irLoad,
    input  logic                       abLoad,
    input  logic                       aluOutLoad,
    input  logic                       lmdLoad,
    input  logic                       regWrite,
    input  logic                       pcLoad,
    input  logic                       busUseAlu,
    input  ctrlPkg::operandA           selA,
    input  ctrlPkg::operandB           selB,
    input  isaPkg::aluOp               aluFunc,
    input  logic [`CPU_DATA_WIDTH-1:0] wbDatR,
    output isaPkg::instrWord           instr,
    output logic                       condMet,
    output logic [`CPU_DATA_WIDTH-1:0] wbAdr,
    output logic [`CPU_DATA_WIDTH-1:0] wbDatW,
    output logic [`CPU_DATA_WIDTH-1:0] outData
);

    logic [`CPU_DATA_WIDTH-1:0]     pc;
    logic [`CPU_DATA_WIDTH-1:0]     npc;
    logic [`CPU_DATA_WIDTH-1:0]     aReg;
    logic [`CPU_DATA_WIDTH-1:0]     bReg;
    logic [`CPU_DATA_WIDTH-1:0]     aluOut;
    logic [`CPU_DATA_WIDTH-1:0]     lmd;
    logic                           useLmd;
    isaPkg::instrWord               fetched;
    logic [`CPU_REG_ADDR_WIDTH-1:0] rsIdx;
    logic [`CPU_REG_ADDR_WIDTH-1:0] rtIdx;
    logic [`CPU_DATA_WIDTH-1:0]     rsData;
    logic [`CPU_DATA_WIDTH-1:0]     rtData;
    logic [`CPU_DATA_WIDTH-1:0]     immExt;
    logic [`CPU_DATA_WIDTH-1:0]     aluA;
    logic [`CPU_DATA_WIDTH-1:0]     aluB;
    logic [`CPU_DATA_WIDTH-1:0]     aluResult;
    logic [`CPU_DATA_WIDTH-1:0]     writeData;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `CPU_RESET_PC;
            useLmd <= 1'b0;
        end else begin
            if (pcLoad) begin
                pc <= busUseAlu ? aluOut : npc;
            end
            // writeback picks lmd only after a load
            if (irLoad) begin
                useLmd <= 1'b0;
            end else if (lmdLoad) begin
                useLmd <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (irLoad) begin
            instr <= wbDatR;
            npc <= pc + `CPU_PC_STEP;
        end
        if (abLoad) begin
            aReg <= rsData;
            bReg <= rtData;
        end
        if (aluOutLoad) begin
            aluOut <= aluResult;
        end
        if (lmdLoad) begin
            lmd <= wbDatR;
        end
    end

    // index from the bus word on the fetch edge so A and B load in decode
    assign fetched = wbDatR;
    assign rsIdx = irLoad ? fetched.aluForm.rs : instr.aluForm.rs;
    assign rtIdx = irLoad ? fetched.aluForm.rt : instr.aluForm.rt;
    assign writeData = useLmd ? lmd : aluOut;

    regFile regFile_i (
        .clk      (clk),
        .reset    (reset),
        .rsIdx    (rsIdx),
        .rtIdx    (rtIdx),
        .rdIdx    (instr.aluForm.rd),
        .writeEn  (regWrite),
        .writeData(writeData),
        .rsData   (rsData),
        .rtData   (rtData)
    );

    assign immExt = {{(`CPU_DATA_WIDTH - `CPU_IMM_WIDTH){instr.aluForm.imm[`CPU_IMM_WIDTH-1]}},
                     instr.aluForm.imm};
    assign aluA = (selA == ctrlPkg::nextPc) ? npc : aReg;
    assign aluB = (selB == ctrlPkg::immediate) ? immExt : bReg;

    alu alu_i (
        .func  (aluFunc),
        .opA   (aluA),
        .opB   (aluB),
        .result(aluResult)
    );

    always_comb begin
        case (isaPkg::branchCond'(instr.ctlForm.variant))
            isaPkg::condAlways:      condMet = 1'b1;
            isaPkg::condNegative:    condMet = aReg[`CPU_DATA_WIDTH-1];
            isaPkg::condNonNegative: condMet = !aReg[`CPU_DATA_WIDTH-1];
            default:                 condMet = (aReg == '0);
        endcase
    end

    assign wbAdr = busUseAlu ? aluOut : pc;
    assign wbDatW = bReg;
    assign outData = aluOut;

endmodule

`default_nettype wire

// File: design/isaPkg.sv
`default_nettype none

`include "cpu_cfg.svh"

package isaPkg;

    // instruction class in bits 31:30
    typedef enum logic [1:0] {
        aluReg  = 2'b00,
        aluImm  = 2'b01,
        branch  = 2'b10,
        special = 2'b11
    } instrClass;

    typedef enum logic [3:0] {
        opAdd  = 4'd0,
        opSub  = 4'd1,
        opAnd  = 4'd2,
        opOr   = 4'd3,
        opXor  = 4'd4,
        opNot  = 4'd5,
        opShl  = 4'd6,
        opSra  = 4'd7,
        opSrl  = 4'd8,
        opPass = 4'd9
    } aluOp;

    // tested on the rs operand
    typedef enum logic [1:0] {
        condAlways      = 2'b00,
        condNegative    = 2'b01,
        condNonNegative = 2'b10,
        condZero        = 2'b11
    } branchCond;

    // other codes do nothing
    typedef enum logic [3:0] {
        kindLoad  = 4'b1100,
        kindStore = 4'b1101,
        kindOut   = 4'b1111
    } specialKind;

    typedef struct packed {
        instrClass                      cls;
        aluOp                           op;
        logic [`CPU_REG_ADDR_WIDTH-1:0] rs;
        logic [`CPU_REG_ADDR_WIDTH-1:0] rt;
        logic [`CPU_REG_ADDR_WIDTH-1:0] rd;
        logic [`CPU_IMM_WIDTH-1:0]      imm;
    } aluFields;

    // branch reads variant as the condition, special reads kind and variant together
    typedef struct packed {
        instrClass                      cls;
        logic [1:0]                     kind;
        logic [1:0]                     variant;
        logic [`CPU_REG_ADDR_WIDTH-1:0] rs;
        logic [`CPU_REG_ADDR_WIDTH-1:0] rt;
        logic [`CPU_REG_ADDR_WIDTH-1:0] rd;
        logic [`CPU_IMM_WIDTH-1:0]      imm;
    } ctlFields;

    typedef union packed {
        aluFields aluForm;
        ctlFields ctlForm;
    } instrWord;

endpackage

`default_nettype wire

// File: design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module regFile (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [`CPU_REG_ADDR_WIDTH-1:0] rsIdx,
    input  logic [`CPU_REG_ADDR_WIDTH-1:0] rtIdx,
    input  logic [`CPU_REG_ADDR_WIDTH-1:0] rdIdx,
    input  logic                           writeEn,
    input  logic [`CPU_DATA_WIDTH-1:0]     writeData,
    output logic [`CPU_DATA_WIDTH-1:0]     rsData,
    output logic [`CPU_DATA_WIDTH-1:0]     rtData
);

    logic [`CPU_DATA_WIDTH-1:0] regs [`CPU_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[rdIdx] <= writeData;
        end
    end

    // registered reads, old value on a same-cycle write
    always_ff @(posedge clk) begin
        rsData <= regs[rsIdx];
        rtData <= regs[rtIdx];
    end

endmodule

`default_nettype wire
